/* common/exe_macros.svh */
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Integer datapath and address width
`define XLEN 32

// One L1.5 response data beat
`define L15_DATA_W 64

// Instruction size, used for link addresses
`define PC_STEP 4

`endif

/* common/exe_pkg.sv */
`include "exe_macros.svh"

package exe_pkg;

	typedef enum logic [2:0] {
		WB_ALU    = 3'd0,
		WB_LINK   = 3'd1, // pc + 4
		WB_MULDIV = 3'd2,
		WB_LUI    = 3'd3,
		WB_MEM    = 3'd4,
		WB_AUIPC  = 3'd5
	} wb_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_fn_e;

	// Same order as funct3 of the M extension
	typedef enum logic [2:0] {
		MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
		MD_DIV, MD_DIVU, MD_REM, MD_REMU
	} muldiv_op_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// L1.5 request encodings
	localparam logic [3:0] L15_LOAD_RQ  = 4'd0;
	localparam logic [3:0] L15_STORE_RQ = 4'd1;
	localparam logic [2:0] L15_SIZE_1B  = 3'd0;
	localparam logic [2:0] L15_SIZE_2B  = 3'd1;
	localparam logic [2:0] L15_SIZE_4B  = 3'd2;

	typedef struct packed {
		wb_sel_e    wb_sel;
		alu_fn_e    alu_fn;
		logic       we;
		logic [4:0] rd;
		logic       btype;
		logic       bneq;  // Inverts the branch condition
		logic       j;
		logic       jr;
		mem_op_e    mem_op;
		muldiv_op_e muldiv_op;
		logic [1:0] pcselect;
	} exe_ctrl_t;

	typedef struct packed {
		logic [`XLEN-1:0] b_imm;
		logic [`XLEN-1:0] j_imm;
		logic [`XLEN-1:0] u_imm;
		logic [`XLEN-1:0] s_imm;
	} exe_imm_t;

	typedef struct packed {
		logic [3:0]       rqtype;
		logic [2:0]       size;
		logic [`XLEN-1:0] address;
		logic [`XLEN-1:0] data;
		logic             val;
	} l15_req_t;

	typedef struct packed {
		logic [`L15_DATA_W-1:0] data_0;
		logic [`L15_DATA_W-1:0] data_1;
		logic [3:0]             returntype;
		logic                   val;
		logic                   ack;
		logic                   header_ack;
	} l15_resp_t;

endpackage

/* design/alu.sv */
`timescale 1ns/10ps
`include "exe_macros.svh"

module alu (
	input exe_pkg::alu_fn_e alu_fn,
	input logic [`XLEN-1:0] operand_a,
	input logic [`XLEN-1:0] operand_b,
	input logic btype,
	input logic bneq,
	output logic [`XLEN-1:0] result,
	output logic btaken
);
	import exe_pkg::*;

	logic lt;
	logic ltu;
	logic eq;
	logic cond;

	assign lt = $signed(operand_a) < $signed(operand_b);
	assign ltu = operand_a < operand_b;
	assign eq = operand_a == operand_b;

	always_comb
	begin
		unique case (alu_fn)
			ALU_ADD:  result = operand_a + operand_b;
			ALU_SUB:  result = operand_a - operand_b;
			ALU_SLL:  result = operand_a << operand_b[4:0];
			ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt};
			ALU_SLTU: result = {{(`XLEN-1){1'b0}}, ltu};
			ALU_XOR:  result = operand_a ^ operand_b;
			ALU_SRL:  result = operand_a >> operand_b[4:0];
			ALU_SRA:  result = $signed(operand_a) >>> operand_b[4:0];
			ALU_OR:   result = operand_a | operand_b;
			ALU_AND:  result = operand_a & operand_b;
			default:  result = '0;
		endcase
	end

	// bneq flips the test, so bne/bge/bgeu come from beq/blt/bltu
	assign cond = (alu_fn == ALU_SLT) ? lt : (alu_fn == ALU_SLTU) ? ltu : eq;
	assign btaken = btype & (cond ^ bneq);

endmodule

/* design/branch_unit.sv */
`timescale 1ns/10ps
`include "exe_macros.svh"

module branch_unit (
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] operand_a,
	input logic [`XLEN-1:0] b_imm,
	input logic [`XLEN-1:0] j_imm,
	input logic [`XLEN-1:0] i_imm,
	input logic btaken,
	input logic j,
	input logic jr,
	output logic [`XLEN-1:0] target
);
	logic [`XLEN-1:0] jalr_sum;

	assign jalr_sum = operand_a + i_imm;

	always_comb
	begin
		if (jr)
			target = {jalr_sum[`XLEN-1:1], 1'b0}; // jalr clears bit 0
		else if (j)
			target = pc + j_imm;
		else
			target = pc + b_imm; // Only used when btaken
	end

endmodule

/* design/mul_div.sv */
`timescale 1ns/10ps
`include "exe_macros.svh"

module mul_div (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input exe_pkg::muldiv_op_e muldiv_op,
	output logic [`XLEN-1:0] res
);
	import exe_pkg::*;

	logic a_signed;
	logic b_signed;
	logic signed [`XLEN:0] ext_a;
	logic signed [`XLEN:0] ext_b;
	logic signed [2*`XLEN+1:0] prod;
	logic signed [`XLEN-1:0] quot_s;
	logic signed [`XLEN-1:0] rem_s;
	logic div_zero;
	logic div_ovf;

	// One 33x33 signed multiplier covers every signedness mix
	assign a_signed = (muldiv_op == MD_MULH) | (muldiv_op == MD_MULHSU);
	assign b_signed = muldiv_op == MD_MULH;
	assign ext_a = {a_signed & a[`XLEN-1], a};
	assign ext_b = {b_signed & b[`XLEN-1], b};
	assign prod = ext_a * ext_b;

	// Signed quotient and remainder, zero divisor masked below
	assign quot_s = $signed(a) / $signed(b);
	assign rem_s = $signed(a) % $signed(b);

	assign div_zero = b == '0;
	assign div_ovf = (a == {1'b1, {(`XLEN-1){1'b0}}}) & (b == '1); // -2^31 / -1

	always_comb
	begin
		unique case (muldiv_op)
			MD_MUL:                      res = prod[`XLEN-1:0];
			MD_MULH, MD_MULHSU, MD_MULHU: res = prod[2*`XLEN-1:`XLEN];
			MD_DIV:  res = div_zero ? '1 : div_ovf ? a : quot_s;
			MD_DIVU: res = div_zero ? '1 : a / b;
			MD_REM:  res = div_zero ? a : div_ovf ? '0 : rem_s;
			MD_REMU: res = div_zero ? a : a % b;
			default: res = '0;
		endcase
	end

endmodule

/* mem_wrap/mem_wrap.sv */
`timescale 1ns/10ps
`include "exe_macros.svh"

module mem_wrap (
	input logic clk,
	input logic nrst,
	input exe_pkg::mem_op_e mem_op,
	input logic [`XLEN-1:0] base,
	input logic [`XLEN-1:0] src,   // Store data, or load offset
	input logic [`XLEN-1:0] s_imm,
	output exe_pkg::l15_req_t req,
	input exe_pkg::l15_resp_t resp,
	output logic req_ack,
	output logic [`XLEN-1:0] mem_out,
	output logic mem_done,
	output logic ld_misaligned,
	output logic st_misaligned
);
	import exe_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_HDR, S_RESP} state_e;

	state_e state;
	logic is_load;
	logic is_store;
	logic misaligned;
	logic issue;
	logic resp_hit;
	logic [2:0] size;
	logic [`XLEN-1:0] addr;
	logic [`XLEN-1:0] st_data;
	logic ld_mis_q;
	logic st_mis_q;
	mem_op_e op_q;
	logic [3:0] rqtype_q;
	logic [2:0] size_q;
	logic [`XLEN-1:0] addr_q;
	logic [`XLEN-1:0] data_q;
	logic [31:0] ld_word;
	logic [15:0] ld_half;
	logic [7:0] ld_byte;

	always_comb
	begin
		is_load = 1'b0;
		is_store = 1'b0;
		size = L15_SIZE_1B;
		st_data = src;
		unique case (mem_op)
			MEM_LB, MEM_LBU: is_load = 1'b1;
			MEM_LH, MEM_LHU:
			begin
				is_load = 1'b1;
				size = L15_SIZE_2B;
			end
			MEM_LW:
			begin
				is_load = 1'b1;
				size = L15_SIZE_4B;
			end
			MEM_SB:
			begin
				is_store = 1'b1;
				st_data = {4{src[7:0]}}; // Byte in every lane
			end
			MEM_SH:
			begin
				is_store = 1'b1;
				size = L15_SIZE_2B;
				st_data = {2{src[15:0]}};
			end
			MEM_SW:
			begin
				is_store = 1'b1;
				size = L15_SIZE_4B;
			end
			default: ;
		endcase
	end

	assign addr = is_store ? base + s_imm : base + src;
	assign misaligned = ((size == L15_SIZE_2B) & addr[0]) | ((size == L15_SIZE_4B) & (|addr[1:0]));
	assign issue = (is_load | is_store) & ~misaligned & (state == S_IDLE);
	assign resp_hit = (state == S_RESP) & resp.val;
	assign req_ack = resp_hit;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= S_IDLE;
			ld_mis_q <= 1'b0;
			st_mis_q <= 1'b0;
			ld_misaligned <= 1'b0;
			st_misaligned <= 1'b0;
			mem_done <= 1'b0;
		end
		else
		begin
			ld_mis_q <= is_load & misaligned;
			st_mis_q <= is_store & misaligned;
			ld_misaligned <= ld_mis_q; // Two cycles after issue
			st_misaligned <= st_mis_q;
			mem_done <= resp_hit | ld_mis_q | st_mis_q;
			unique case (state)
				S_IDLE: if (issue) state <= S_HDR;
				S_HDR:  if (resp.header_ack) state <= S_RESP;
				S_RESP: if (resp.val) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			op_q <= mem_op;
			rqtype_q <= is_store ? L15_STORE_RQ : L15_LOAD_RQ;
			size_q <= size;
			addr_q <= addr;
			data_q <= st_data;
		end
		if (resp_hit)
			mem_out <= load_ext(op_q);
	end

	// Word by address bit 2, then lane within it
	assign ld_word = addr_q[2] ? resp.data_0[63:32] : resp.data_0[31:0];
	assign ld_half = addr_q[1] ? ld_word[31:16] : ld_word[15:0];
	assign ld_byte = ld_word[{addr_q[1:0], 3'b000} +: 8];

	function automatic logic [`XLEN-1:0] load_ext(input mem_op_e op);
		unique case (op)
			MEM_LB:  load_ext = {{24{ld_byte[7]}}, ld_byte};
			MEM_LBU: load_ext = {24'b0, ld_byte};
			MEM_LH:  load_ext = {{16{ld_half[15]}}, ld_half};
			MEM_LHU: load_ext = {16'b0, ld_half};
			default: load_ext = ld_word;
		endcase
	endfunction

	assign req = '{
		rqtype:  rqtype_q,
		size:    size_q,
		address: addr_q,
		data:    data_q,
		val:     state == S_HDR
	};

	// Request must not change under the L1.5 until it is accepted
	assert property (@(posedge clk) disable iff (!nrst)
		req.val && !resp.header_ack |=> req.val && $stable(req));

	// One access in flight, issuer holds off further memory ops
	assert property (@(posedge clk) disable iff (!nrst)
		(state != S_IDLE) || ld_mis_q || st_mis_q |-> mem_op == MEM_NONE);

endmodule

/* exe_stage/exe_stage.sv */
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_stage (
	input logic clk,
	input logic nrst,
	input exe_pkg::exe_ctrl_t ctrl4,
	input exe_pkg::exe_imm_t imm4,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] op_b,
	input logic [`XLEN-1:0] pc4,
	output logic [`XLEN-1:0] wb_data6,
	output logic we6,
	output logic [4:0] rd6,
	output logic [`XLEN-1:0] pc6,
	output logic [`XLEN-1:0] target,
	output logic bjtaken6,
	output logic [1:0] pcselect5,
	output exe_pkg::l15_req_t l15_req,
	input exe_pkg::l15_resp_t l15_resp,
	output logic req_ack,
	output logic mem_done,
	output logic ld_addr_misaligned6,
	output logic samo_addr_misaligned6
);
	import exe_pkg::*;

	// Pipe 5
	exe_ctrl_t ctrl5;
	exe_imm_t imm5;
	logic [`XLEN-1:0] opa5;
	logic [`XLEN-1:0] opb5;   // Also the I immediate for jalr
	logic [`XLEN-1:0] pc5;
	logic [`XLEN-1:0] alu_res5;
	logic [`XLEN-1:0] muldiv5;
	logic [`XLEN-1:0] mem_out;
	logic btaken;

	// Pipe 6
	wb_sel_e wb_sel6;
	logic we_r6;
	logic mem6;     // Entry is a load or store
	logic hold6;
	logic [4:0] rd_r6;
	logic [`XLEN-1:0] alu_res6;
	logic [`XLEN-1:0] muldiv6;
	logic [`XLEN-1:0] u_imm6;
	logic [`XLEN-1:0] auipc6;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			ctrl5 <= '0;
		else
			ctrl5 <= ctrl4;
	end

	always_ff @(posedge clk)
	begin
		imm5 <= imm4;
		opa5 <= op_a;
		opb5 <= op_b;
		pc5 <= pc4;
	end

	alu alu_i (
		.alu_fn    (ctrl5.alu_fn),
		.operand_a (opa5),
		.operand_b (opb5),
		.btype     (ctrl5.btype),
		.bneq      (ctrl5.bneq),
		.result    (alu_res5),
		.btaken    (btaken)
	);

	branch_unit branch_unit_i (
		.pc        (pc5),
		.operand_a (opa5),
		.b_imm     (imm5.b_imm),
		.j_imm     (imm5.j_imm),
		.i_imm     (opb5),
		.btaken    (btaken),
		.j         (ctrl5.j),
		.jr        (ctrl5.jr),
		.target    (target)
	);

	mul_div mul_div_i (
		.a         (opa5),
		.b         (opb5),
		.muldiv_op (ctrl5.muldiv_op),
		.res       (muldiv5)
	);

	// Memory side works straight from the issue inputs
	mem_wrap mem_wrap_i (
		.clk           (clk),
		.nrst          (nrst),
		.mem_op        (ctrl4.mem_op),
		.base          (op_a),
		.src           (op_b),
		.s_imm         (imm4.s_imm),
		.req           (l15_req),
		.resp          (l15_resp),
		.req_ack       (req_ack),
		.mem_out       (mem_out),
		.mem_done      (mem_done),
		.ld_misaligned (ld_addr_misaligned6),
		.st_misaligned (samo_addr_misaligned6)
	);

	assign hold6 = mem6 & ~mem_done; // Keep the load entry until data returns

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wb_sel6 <= WB_ALU;
			we_r6 <= 1'b0;
			mem6 <= 1'b0;
			rd_r6 <= '0;
		end
		else if (!hold6)
		begin
			wb_sel6 <= ctrl5.wb_sel;
			we_r6 <= ctrl5.we;
			mem6 <= ctrl5.mem_op != MEM_NONE;
			rd_r6 <= ctrl5.rd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!hold6)
		begin
			alu_res6 <= alu_res5;
			muldiv6 <= muldiv5;
			u_imm6 <= imm5.u_imm;
			auipc6 <= imm5.u_imm + pc5;
			pc6 <= pc5;
		end
	end

	always_comb
	begin
		unique case (wb_sel6)
			WB_ALU:    wb_data6 = alu_res6;
			WB_LINK:   wb_data6 = pc6 + `PC_STEP;
			WB_MULDIV: wb_data6 = muldiv6;
			WB_LUI:    wb_data6 = u_imm6;
			WB_MEM:    wb_data6 = mem_out;
			WB_AUIPC:  wb_data6 = auipc6;
			default:   wb_data6 = '0;
		endcase
	end

	// Misaligned access finishes without a write
	assign we6 = we_r6 & (~mem6 | (mem_done & ~ld_addr_misaligned6 & ~samo_addr_misaligned6));
	assign rd6 = rd_r6;

	assign bjtaken6 = btaken | ctrl5.j | ctrl5.jr;
	assign pcselect5 = bjtaken6 ? ctrl5.pcselect : 2'b00;

	// A memory entry writes back only right after the L1.5 response
	assert property (@(posedge clk) disable iff (!nrst)
		mem6 && we6 |-> $past(req_ack));

endmodule

/* tests/exe_tb.sv */
`timescale 1ns/10ps

module exe_tb;
	import exe_pkg::*;

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int REC_W = 26; // Words per trace record
	localparam int MAX_REC = 32;
	localparam string TRACE_FILE = "tests/exe_trace.txt";

	logic clk;
	logic nrst;
	exe_ctrl_t ctrl4;
	exe_imm_t imm4;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] pc4;
	logic [31:0] wb_data6;
	logic we6;
	logic [4:0] rd6;
	logic [31:0] pc6;
	logic [31:0] target;
	logic bjtaken6;
	logic [1:0] pcselect5;
	l15_req_t l15_req;
	l15_resp_t l15_resp;
	logic req_ack;
	logic mem_done;
	logic ld_addr_misaligned6;
	logic samo_addr_misaligned6;

	logic [31:0] trace [0:REC_W*MAX_REC-1];
	int rec_fail [0:MAX_REC-1];
	int num_rec;
	int errors;
	int tests_done;
	int p1;
	int p2;
	int mem_rec;   // Record whose access the L1.5 model serves
	bit req_seen;
	int wd_cycles;

	exe_stage exe_stage_i (.*);

	always #(PERIOD/2) clk = ~clk;

	function automatic logic [31:0] fld(input int r, input int f);
		return trace[r*REC_W+f];
	endfunction

	task automatic compare_val(input int r, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] test %0d %s: got %h expected %h", r, name, got, exp);
			errors++;
			if (r >= 0)
				rec_fail[r]++;
		end
	endtask

	task automatic report_test(input int r);
		$display("test %0d: %s", r, (rec_fail[r] == 0) ? "ok" : "FAIL");
		tests_done++;
	endtask

	task automatic drive_issue(input int r);
		ctrl4 = '0;
		imm4 = '0;
		op_a = '0;
		op_b = '0;
		pc4 = '0;
		if (r >= 0)
		begin
			ctrl4.wb_sel = wb_sel_e'(3'(fld(r, 0)));
			ctrl4.alu_fn = alu_fn_e'(4'(fld(r, 1)));
			ctrl4.we = 1'(fld(r, 2));
			ctrl4.rd = 5'(fld(r, 3));
			{ctrl4.btype, ctrl4.bneq, ctrl4.j, ctrl4.jr} = 4'(fld(r, 4));
			ctrl4.mem_op = mem_op_e'(4'(fld(r, 5)));
			ctrl4.muldiv_op = muldiv_op_e'(3'(fld(r, 6)));
			ctrl4.pcselect = 2'(fld(r, 7));
			op_a = fld(r, 8);
			op_b = fld(r, 9);
			pc4 = fld(r, 10);
			imm4.b_imm = fld(r, 11);
			imm4.j_imm = fld(r, 12);
			imm4.u_imm = fld(r, 13);
			imm4.s_imm = fld(r, 14);
		end
	endtask

	task automatic check_branch(input int r);
		compare_val(r, "bjtaken6", bjtaken6, fld(r, 21));
		compare_val(r, "pcselect5", pcselect5, (fld(r, 21) != 0) ? fld(r, 7) : 32'd0);
		if (fld(r, 21) != 0)
			compare_val(r, "target", target, fld(r, 20));
	endtask

	task automatic check_wb(input int r);
		compare_val(r, "we6", we6, fld(r, 19));
		compare_val(r, "pc6", pc6, fld(r, 10));
		if (fld(r, 19) != 0)
		begin
			compare_val(r, "wb_data6", wb_data6, fld(r, 18));
			compare_val(r, "rd6", rd6, fld(r, 3));
		end
	endtask

	// One issue slot, two results in flight behind it
	task automatic advance(input int next);
		@(negedge clk);
		if (p1 >= 0)
			check_branch(p1);
		if (p2 >= 0)
		begin
			check_wb(p2);
			report_test(p2);
		end
		drive_issue(next);
		p2 = p1;
		p1 = next;
	endtask

	task automatic run_mem(input int r);
		int cnt;
		advance(-1); // Drain the pipe first
		advance(-1);
		@(negedge clk);
		mem_rec = r;
		req_seen = 0;
		drive_issue(r);
		@(negedge clk);
		drive_issue(-1);
		cnt = 0;
		while (!mem_done)
		begin
			compare_val(r, "we6", we6, 0);
			cnt++;
			if (cnt > fld(r, 15) + 8)
			begin
				$display("test %0d: memory access did not complete", r);
				errors++;
				rec_fail[r]++;
				break;
			end
			@(negedge clk);
		end
		check_wb(r);
		compare_val(r, "misaligned", {samo_addr_misaligned6, ld_addr_misaligned6}, fld(r, 22));
		compare_val(r, "l15_req.val", req_seen, fld(r, 22) == 0);
		report_test(r);
	endtask

	// L1.5 model: header ack a cycle after req.val, then response after the trace delay
	always
	begin
		@(negedge clk);
		if (l15_req.val)
		begin
			req_seen = 1;
			compare_val(mem_rec, "l15_req.address", l15_req.address, fld(mem_rec, 23));
			compare_val(mem_rec, "l15_req.data", l15_req.data, fld(mem_rec, 24));
			compare_val(mem_rec, "l15_req.type", {l15_req.rqtype, 1'b0, l15_req.size},
				fld(mem_rec, 25));
			l15_resp.header_ack = 1'b1;
			@(negedge clk);
			l15_resp.header_ack = 1'b0;
			repeat (fld(mem_rec, 15)) @(negedge clk);
			l15_resp.data_0 = {fld(mem_rec, 16), fld(mem_rec, 17)};
			l15_resp.val = 1'b1;
			@(posedge clk);
			compare_val(mem_rec, "req_ack", req_ack, 1); // Response taken at this edge
			@(negedge clk);
			l15_resp.val = 1'b0;
		end
	end

	initial
	begin
		wait (wd_cycles > 0);
		#(wd_cycles * PERIOD);
		$display("Watchdog expired after %0d cycles", wd_cycles);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int max_dly;
		clk = 0;
		nrst = 0;
		l15_resp = '0;
		errors = 0;
		tests_done = 0;
		p1 = -1;
		p2 = -1;
		mem_rec = 0;
		req_seen = 0;
		wd_cycles = 0;
		drive_issue(-1);
		foreach (trace[k])
			trace[k] = ~k; // Unread words keep a fill that no 3-bit wb_sel matches
		foreach (rec_fail[k])
			rec_fail[k] = 0;
		$readmemh(TRACE_FILE, trace);
		num_rec = 0;
		max_dly = 0;
		while (num_rec < MAX_REC && fld(num_rec, 0) <= 32'd7)
		begin
			if (fld(num_rec, 15) > max_dly)
				max_dly = fld(num_rec, 15);
			num_rec++;
		end
		wd_cycles = num_rec * (max_dly + 4) + 20 + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		nrst = 1;
		for (int r = 0; r < num_rec; r++)
		begin
			if (fld(r, 5) != 0)
				run_mem(r);
			else
				advance(r);
		end
		advance(-1);
		advance(-1);
		$display("%0d tests run, %0d errors", tests_done, errors);
		if (errors == 0 && tests_done == num_rec && num_rec > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* tests/exe_trace.txt */
// Per record, line 1: wb_sel alu_fn we rd {btype,bneq,j,jr} mem_op md_op pcsel op_a op_b pc b j u s
// line 2: delay data_hi data_lo exp_wb exp_we exp_target exp_bj exp_mis exp_addr exp_sdata {type,size}
0 0 1 1 0 0 0 0 00000005 00000007 00000100 0 0 0 0
0 0 0 0000000c 1 0 0 0 0 0 0
0 1 1 2 0 0 0 0 00000003 00000005 00000104 0 0 0 0
0 0 0 fffffffe 1 0 0 0 0 0 0
0 7 1 3 0 0 0 0 80000000 00000004 00000108 0 0 0 0
0 0 0 f8000000 1 0 0 0 0 0 0
0 3 0 0 8 0 0 1 fffffffe 00000001 00000200 00000010 0 0 0
0 0 0 0 0 00000210 1 0 0 0 0
0 0 0 0 c 0 0 1 00000005 00000005 00000204 00000020 0 0 0
0 0 0 0 0 0 0 0 0 0 0
1 0 1 1 2 0 0 2 0 0 00000300 0 00000040 0 0
0 0 0 00000304 1 00000340 1 0 0 0 0
1 0 1 1 1 0 0 3 00001001 00000006 00000400 0 0 0 0
0 0 0 00000404 1 00001006 1 0 0 0 0
3 0 1 5 0 0 0 0 0 0 00000500 0 0 12345000 0
0 0 0 12345000 1 0 0 0 0 0 0
5 0 1 6 0 0 0 0 0 0 00000500 0 0 00001000 0
0 0 0 00001500 1 0 0 0 0 0 0
2 0 1 7 0 0 1 0 80000000 00000002 00000504 0 0 0 0
0 0 0 ffffffff 1 0 0 0 0 0 0
2 0 1 7 0 0 3 0 ffffffff ffffffff 00000508 0 0 0 0
0 0 0 fffffffe 1 0 0 0 0 0 0
2 0 1 8 0 0 4 0 00000007 00000000 0000050c 0 0 0 0
0 0 0 ffffffff 1 0 0 0 0 0 0
2 0 1 9 0 0 6 0 80000000 ffffffff 00000510 0 0 0 0
0 0 0 00000000 1 0 0 0 0 0 0
4 0 1 a 0 1 0 0 00001000 00000005 00000600 0 0 0 0
2 8899aabb 00000000 ffffffaa 1 0 0 0 00001005 00000005 00
4 0 1 b 0 5 0 0 00002000 00000002 00000604 0 0 0 0
0 00000000 1234cdef 00001234 1 0 0 0 00002002 00000002 01
4 0 1 c 0 3 0 0 00003000 00000004 00000608 0 0 0 0
5 deadbeef 00000000 deadbeef 1 0 0 0 00003004 00000004 02
0 0 0 0 0 6 0 0 00004000 000000a5 0000060c 0 0 0 00000003
1 0 0 0 0 0 0 0 00004003 a5a5a5a5 10
0 0 0 0 0 8 0 0 00005000 cafef00d 00000610 0 0 0 00000008
0 0 0 0 0 0 0 0 00005008 cafef00d 12
4 0 1 c 0 3 0 0 00006000 00000002 00000614 0 0 0 0
0 0 0 0 0 0 0 1 0 0 0
0 0 0 0 0 7 0 0 00006000 00000000 00000618 0 0 0 00000001
0 0 0 0 0 0 0 2 0 0 0
0 8 1 d 0 0 0 0 f0f0f0f0 0f0f0f0f 0000061c 0 0 0 0
0 0 0 ffffffff 1 0 0 0 0 0 0

/* build.f */
+incdir+common
common/exe_pkg.sv
design/alu.sv
design/branch_unit.sv
design/mul_div.sv
mem_wrap/mem_wrap.sv
exe_stage/exe_stage.sv
tests/exe_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module exe_tb -o exe_sim
out=$(./obj_dir/exe_sim)
echo "$out"
echo "$out" | grep -q "Test completed successfully"
